//--- busPkg.sv
package busPkg;

    // host to node
    typedef struct packed {
        logic       cyc;    // cycle in progress
        logic       stb;    // strobe
        logic       we;     // write enable
        logic [7:0] adr;
        logic [7:0] dat;
    } busReq_t;

    // node to host
    typedef struct packed {
        logic       ack;
        logic [7:0] dat;
    } busRsp_t;

endpackage

//--- hostRegs.sv
`include "router_consts.svh"

module hostRegs
    import msgPkg::*;
    import busPkg::*;
(
    input  logic    clk_i,
    input  logic    rst_i,
    input  busReq_t bus_i,
    output busRsp_t bus_o,
    input  msg_t    fifoHead_i,
    input  logic    fifoEmpty_i,
    output logic    fifoPop_o,
    output msg_t    txMsg_o,
    output logic    sendReq_o,
    input  logic    sendTaken_i
);

    logic              access;
    logic              wrEn;
    logic              winHit;      // byte window 0x00..0x0F
    logic              sendPending;
    logic [`MSG_W-1:0] txBits;
    logic [`MSG_W-1:0] headBits;
    logic [7:0]        rdData;

    assign access   = bus_i.cyc && bus_i.stb;
    assign wrEn     = access && bus_i.we;
    assign winHit   = (bus_i.adr[7:4] == 4'h0);
    assign headBits = fifoHead_i;

    assign fifoPop_o = wrEn && (bus_i.adr == `REG_POP) && !fifoEmpty_i;
    assign sendReq_o = sendPending;
    assign txMsg_o   = msg_t'(txBits);

    // ------------------------------------------------------------
    // read side
    // ------------------------------------------------------------
    always_comb begin
        rdData = 8'h00;
        if (winHit)
            rdData = headBits[{bus_i.adr[3:0], 3'b000} +: 8];
        else if (bus_i.adr == `REG_POP)
            rdData = {7'b0, !fifoEmpty_i};
        else if (bus_i.adr == `REG_SEND)
            rdData = {7'b0, sendPending};
    end

    always_comb begin
        bus_o.ack = access;     // single cycle, no wait states
        bus_o.dat = rdData;
    end

    // ------------------------------------------------------------
    // write side
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sendPending <= 1'b0;
        end else begin
            if (sendTaken_i)
                sendPending <= 1'b0;
            else if (wrEn && (bus_i.adr == `REG_SEND))
                sendPending <= 1'b1;
        end
    end

    // message frozen while the engine may still copy it
    always_ff @(posedge clk_i) begin
        if (wrEn && winHit && !sendPending)
            txBits[{bus_i.adr[3:0], 3'b000} +: 8] <= bus_i.dat;
    end

endmodule

//--- linkRx.sv
`include "router_consts.svh"

module linkRx
    import msgPkg::*;
(
    input  logic clk_i,
    input  logic rst_i,
    input  logic rxd_i,         // serial line, idles high
    input  logic take_i,        // engine copies msg_o
    output msg_t msg_o,
    output logic dataPresent_o
);

    localparam int CNT_W = $clog2(`MSG_W + 1);
    localparam logic [CNT_W-1:0] STOP_POS = CNT_W'(`MSG_W);

    logic              busy;        // inside a frame
    logic [CNT_W-1:0]  bitCnt;      // data bits collected
    logic [`MSG_W-1:0] shiftReg;
    logic              atStop;
    logic              accept;

    assign atStop = busy && (bitCnt == STOP_POS);
    // full buffer drops the frame unless it is emptied this cycle
    assign accept = atStop && rxd_i && (!dataPresent_o || take_i);

    // ------------------------------------------------------------
    // frame control
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy          <= 1'b0;
            bitCnt        <= '0;
            dataPresent_o <= 1'b0;
        end else begin
            if (take_i)
                dataPresent_o <= 1'b0;
            if (!busy) begin
                if (!rxd_i) begin       // start bit
                    busy   <= 1'b1;
                    bitCnt <= '0;
                end
            end else if (atStop) begin
                busy <= 1'b0;           // bad stop bit just drops the frame
                if (accept)
                    dataPresent_o <= 1'b1;
            end else begin
                bitCnt <= bitCnt + 1'b1;
            end
        end
    end

    // lsb arrives first, so shift in from the top
    always_ff @(posedge clk_i) begin
        if (busy && !atStop)
            shiftReg <= {rxd_i, shiftReg[`MSG_W-1:1]};
        if (accept)
            msg_o <= msg_t'(shiftReg);
    end

endmodule

//--- linkTx.sv
`include "router_consts.svh"

module linkTx
    import msgPkg::*;
(
    input  logic clk_i,
    input  logic rst_i,
    input  logic load_i,        // only while empty_o is high
    input  msg_t msg_i,
    output logic txd_o,
    output logic empty_o
);

    localparam int CNT_W = $clog2(`MSG_W + 3);
    localparam logic [CNT_W-1:0] LAST_DATA = CNT_W'(`MSG_W);
    localparam logic [CNT_W-1:0] STOP_POS  = CNT_W'(`MSG_W + 1);

    logic [CNT_W-1:0]  bitCnt;
    logic [`MSG_W-1:0] shiftReg;
    logic              dataPhase;

    assign dataPhase = !empty_o && (bitCnt != '0) && (bitCnt <= LAST_DATA);

    // ------------------------------------------------------------
    // sequencing: gap, start, 128 data, stop, then empty again
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            txd_o   <= 1'b1;
            empty_o <= 1'b1;
            bitCnt  <= '0;
        end else if (empty_o) begin
            txd_o <= 1'b1;              // idle line
            if (load_i) begin
                empty_o <= 1'b0;
                bitCnt  <= '0;
            end
        end else begin
            bitCnt <= bitCnt + 1'b1;
            if (bitCnt == '0)
                txd_o <= 1'b0;          // start bit
            else if (bitCnt <= LAST_DATA)
                txd_o <= shiftReg[0];
            else if (bitCnt == STOP_POS)
                txd_o <= 1'b1;          // stop bit
            else
                empty_o <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (empty_o && load_i)
            shiftReg <= msg_i;
        else if (dataPhase)
            shiftReg <= shiftReg >> 1;  // lsb first
    end

endmodule

//--- list.f
+incdir+.
msgPkg.sv
busPkg.sv
linkRx.sv
linkTx.sv
localFifo.sv
hostRegs.sv
routeEngine.sv
routerNode.sv
routerNode_chk.sv
routerNode_tb.sv

//--- localFifo.sv
`include "router_consts.svh"

module localFifo
    import msgPkg::*;
#(
    parameter int DEPTH = `LFIFO_DEPTH
) (
    input  logic clk_i,
    input  logic rst_i,
    input  logic push_i,
    input  msg_t pushMsg_i,
    input  logic pop_i,
    output msg_t head_o,        // oldest entry
    output logic empty_o,
    output logic full_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(DEPTH - 1);

    msg_t             mem [DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;
    logic             doPush;
    logic             doPop;

    assign doPush  = push_i && !full_o;
    assign doPop   = pop_i && !empty_o;
    assign empty_o = (count == '0);
    assign full_o  = (count == CNT_W'(DEPTH));
    assign head_o  = mem[rdPtr];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush)
                wrPtr <= (wrPtr == LAST_IDX) ? '0 : wrPtr + 1'b1;
            if (doPop)
                rdPtr <= (rdPtr == LAST_IDX) ? '0 : rdPtr + 1'b1;
            if (doPush && !doPop)
                count <= count + 1'b1;
            else if (doPop && !doPush)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (doPush)
            mem[wrPtr] <= pushMsg_i;
    end

endmodule

//--- msgPkg.sv
package msgPkg;

    // ------------------------------------------------------------
    // message layout, MSB first
    // ------------------------------------------------------------
    typedef struct packed {
        logic [2:0]  dstX;      // destination column
        logic        padX;
        logic [2:0]  dstY;      // destination row
        logic        padY;
        logic [7:0]  src;
        logic [31:0] route;     // hop record, two bits per hop
        logic [7:0]  ctrl;      // routing mode
        logic [7:0]  age;       // hops taken so far
        logic [63:0] payload;
    } msg_t;

    // control byte values, anything else is discarded
    typedef enum logic [7:0] {
        CTRL_NORMAL = 8'h00,    // x first, then y
        CTRL_FORCED = 8'h01     // follow the route record
    } ctrlMode_e;

    // hop code stored in the route record
    typedef enum logic [1:0] {
        DIR_LOCAL = 2'b00,
        DIR_X     = 2'b01,
        DIR_Y     = 2'b10
    } routeDir_t;

endpackage

//--- routeEngine.sv
`include "router_consts.svh"

module routeEngine
    import msgPkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic [2:0] nodeX_i,
    input  logic [2:0] nodeY_i,
    input  msg_t       rxXMsg_i,
    input  logic       rxXPresent_i,
    output logic       rxXTake_o,
    input  msg_t       rxYMsg_i,
    input  logic       rxYPresent_i,
    output logic       rxYTake_o,
    output logic       txXLoad_o,
    output msg_t       txXMsg_o,
    input  logic       txXEmpty_i,
    output logic       txYLoad_o,
    output msg_t       txYMsg_o,
    input  logic       txYEmpty_i,
    output logic       fifoPush_o,
    output msg_t       fifoMsg_o,
    input  logic       fifoFull_i,
    input  msg_t       hostMsg_i,
    input  logic       hostReq_i,
    output logic       hostTaken_o
);

    typedef enum logic [1:0] {IDLE, DECIDE, BCAST_X, BCAST_Y} engState_e;

    engState_e  state;
    msg_t       cur;            // message being routed
    logic       isBcast;
    logic       modeOk;         // known control byte
    routeDir_t  dir;
    logic [31:0] fwdRoute;
    msg_t       fwdMsg;
    msg_t       bcXMsg;
    msg_t       bcYMsg;
    logic       deciding;

    function automatic msg_t aged(msg_t m);
        msg_t r;
        r     = m;
        r.age = m.age + 8'd1;
        return r;
    endfunction

    // ------------------------------------------------------------
    // arbitration: x link, y link, host
    // ------------------------------------------------------------
    assign rxXTake_o   = (state == IDLE) && rxXPresent_i;
    assign rxYTake_o   = (state == IDLE) && !rxXPresent_i && rxYPresent_i;
    assign hostTaken_o = (state == IDLE) && !rxXPresent_i && !rxYPresent_i && hostReq_i;

    // ------------------------------------------------------------
    // routing decision
    // ------------------------------------------------------------
    assign isBcast = ({cur.dstX, cur.padX, cur.dstY, cur.padY} == `BCAST_DST);

    always_comb begin
        dir      = DIR_LOCAL;
        fwdRoute = cur.route;
        modeOk   = 1'b1;
        case (cur.ctrl)
            CTRL_NORMAL: begin
                if (cur.dstX != nodeX_i) begin
                    dir      = DIR_X;
                    fwdRoute = {cur.route[29:0], DIR_X};
                end else if (cur.dstY != nodeY_i) begin
                    dir      = DIR_Y;
                    fwdRoute = {cur.route[29:0], DIR_Y};
                end
            end
            CTRL_FORCED: begin
                if (cur.route[31:30] == DIR_X || cur.route[31:30] == DIR_Y) begin
                    dir      = routeDir_t'(cur.route[31:30]);
                    fwdRoute = {cur.route[29:0], 2'b00};    // consume one hop
                end
            end
            default: modeOk = 1'b0;
        endcase
    end

    always_comb begin
        fwdMsg       = cur;
        fwdMsg.route = fwdRoute;
        bcXMsg       = cur;
        bcXMsg.route = {cur.route[29:0], DIR_X};
        bcYMsg       = cur;
        bcYMsg.route = {cur.route[29:0], DIR_Y};
    end

    assign deciding  = (state == DECIDE) && modeOk;
    assign txXMsg_o  = isBcast ? bcXMsg : fwdMsg;
    assign txYMsg_o  = isBcast ? bcYMsg : fwdMsg;
    assign fifoMsg_o = cur;

    // dispatch only into a free target
    assign txXLoad_o  = txXEmpty_i && ((deciding && (isBcast || dir == DIR_X))
                                      || state == BCAST_X);
    assign txYLoad_o  = txYEmpty_i && ((deciding && !isBcast && dir == DIR_Y)
                                      || state == BCAST_Y);
    assign fifoPush_o = !fifoFull_i && deciding && !isBcast && dir == DIR_LOCAL;

    // ------------------------------------------------------------
    // state machine
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (rxXPresent_i)
                        state <= (rxXMsg_i.age > `AGE_LIMIT) ? IDLE : DECIDE;
                    else if (rxYPresent_i)
                        state <= (rxYMsg_i.age > `AGE_LIMIT) ? IDLE : DECIDE;
                    else if (hostReq_i)
                        state <= DECIDE;
                end
                DECIDE: begin
                    if (!modeOk)
                        state <= IDLE;          // unknown control byte
                    else if (isBcast)
                        state <= txXEmpty_i ? BCAST_Y : BCAST_X;
                    else if (txXLoad_o || txYLoad_o || fifoPush_o)
                        state <= IDLE;
                end
                BCAST_X: if (txXEmpty_i) state <= BCAST_Y;
                BCAST_Y: if (txYEmpty_i) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // host messages keep their age
    always_ff @(posedge clk_i) begin
        if (rxXTake_o)
            cur <= aged(rxXMsg_i);
        else if (rxYTake_o)
            cur <= aged(rxYMsg_i);
        else if (hostTaken_o)
            cur <= hostMsg_i;
    end

endmodule

//--- routerNode.sv
module routerNode
    import msgPkg::*;
    import busPkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic [2:0] nodeX_i,     // mesh position
    input  logic [2:0] nodeY_i,
    input  busReq_t    bus_i,
    output busRsp_t    bus_o,
    input  logic       rxdX_i,
    input  logic       rxdY_i,
    output logic       txdX_o,
    output logic       txdY_o
);

    // ------------------------------------------------------------
    // interconnect
    // ------------------------------------------------------------
    msg_t rxXMsg, rxYMsg;
    logic rxXPresent, rxYPresent, rxXTake, rxYTake;
    msg_t txXMsg, txYMsg;
    logic txXLoad, txYLoad, txXEmpty, txYEmpty;
    msg_t fifoIn, fifoHead;
    logic fifoPush, fifoPop, fifoEmpty, fifoFull;
    msg_t hostMsg;
    logic hostReq, hostTaken;

    linkRx rxX (
        .clk_i(clk_i), .rst_i(rst_i), .rxd_i(rxdX_i), .take_i(rxXTake),
        .msg_o(rxXMsg), .dataPresent_o(rxXPresent)
    );

    linkRx rxY (
        .clk_i(clk_i), .rst_i(rst_i), .rxd_i(rxdY_i), .take_i(rxYTake),
        .msg_o(rxYMsg), .dataPresent_o(rxYPresent)
    );

    linkTx txX (
        .clk_i(clk_i), .rst_i(rst_i), .load_i(txXLoad), .msg_i(txXMsg),
        .txd_o(txdX_o), .empty_o(txXEmpty)
    );

    linkTx txY (
        .clk_i(clk_i), .rst_i(rst_i), .load_i(txYLoad), .msg_i(txYMsg),
        .txd_o(txdY_o), .empty_o(txYEmpty)
    );

    localFifo fifo (
        .clk_i(clk_i), .rst_i(rst_i),
        .push_i(fifoPush), .pushMsg_i(fifoIn), .pop_i(fifoPop),
        .head_o(fifoHead), .empty_o(fifoEmpty), .full_o(fifoFull)
    );

    hostRegs regs (
        .clk_i(clk_i), .rst_i(rst_i), .bus_i(bus_i), .bus_o(bus_o),
        .fifoHead_i(fifoHead), .fifoEmpty_i(fifoEmpty), .fifoPop_o(fifoPop),
        .txMsg_o(hostMsg), .sendReq_o(hostReq), .sendTaken_i(hostTaken)
    );

    routeEngine engine (
        .clk_i(clk_i), .rst_i(rst_i), .nodeX_i(nodeX_i), .nodeY_i(nodeY_i),
        .rxXMsg_i(rxXMsg), .rxXPresent_i(rxXPresent), .rxXTake_o(rxXTake),
        .rxYMsg_i(rxYMsg), .rxYPresent_i(rxYPresent), .rxYTake_o(rxYTake),
        .txXLoad_o(txXLoad), .txXMsg_o(txXMsg), .txXEmpty_i(txXEmpty),
        .txYLoad_o(txYLoad), .txYMsg_o(txYMsg), .txYEmpty_i(txYEmpty),
        .fifoPush_o(fifoPush), .fifoMsg_o(fifoIn), .fifoFull_i(fifoFull),
        .hostMsg_i(hostMsg), .hostReq_i(hostReq), .hostTaken_o(hostTaken)
    );

endmodule

//--- routerNode_chk.sv
module routerNode_chk
    import busPkg::*;
(
    input logic    clk_i,
    input logic    rst_i,
    input busReq_t busReq_i,
    input busRsp_t busRsp_i,
    input logic    txdX_i,
    input logic    txdY_i,
    input logic    txXEmpty_i,
    input logic    txYEmpty_i,
    input logic    txXLoad_i,
    input logic    txYLoad_i,
    input logic    fifoPush_i,
    input logic    fifoFull_i,
    input logic    rxXPresent_i,
    input logic    rxYPresent_i,
    input logic    rxXTake_i,
    input logic    rxYTake_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int errCnt = 0;     // failures so far

    // ------------------------------------------------------------
    // bus and fifo
    // ------------------------------------------------------------
    ackMatch: assert property (@(posedge clk_i) disable iff (rst_i)
            busRsp_i.ack == (busReq_i.cyc && busReq_i.stb))
        else begin
            $error("bus ack differs from cyc and stb");
            errCnt++;
        end

    noPushFull: assert property (@(posedge clk_i) disable iff (rst_i)
            !(fifoPush_i && fifoFull_i))
        else begin
            $error("local FIFO pushed while full");
            errCnt++;
        end

    // ------------------------------------------------------------
    // links
    // ------------------------------------------------------------
    property idleHigh(empty, txd);
        @(posedge clk_i) disable iff (rst_i) empty |-> txd;
    endproperty

    property loadWhenEmpty(load, empty);
        @(posedge clk_i) disable iff (rst_i) load |-> empty;
    endproperty

    // buffer must not vanish before the engine takes it
    property holdUntilTake(present, take);
        @(posedge clk_i) disable iff (rst_i) present && !take |=> present;
    endproperty

    idleX: assert property (idleHigh(txXEmpty_i, txdX_i))
        else begin
            $error("txdX low while X transmitter empty");
            errCnt++;
        end

    idleY: assert property (idleHigh(txYEmpty_i, txdY_i))
        else begin
            $error("txdY low while Y transmitter empty");
            errCnt++;
        end

    loadX: assert property (loadWhenEmpty(txXLoad_i, txXEmpty_i))
        else begin
            $error("X transmitter loaded while busy");
            errCnt++;
        end

    loadY: assert property (loadWhenEmpty(txYLoad_i, txYEmpty_i))
        else begin
            $error("Y transmitter loaded while busy");
            errCnt++;
        end

    holdX: assert property (holdUntilTake(rxXPresent_i, rxXTake_i))
        else begin
            $error("X receive buffer cleared without take");
            errCnt++;
        end

    holdY: assert property (holdUntilTake(rxYPresent_i, rxYTake_i))
        else begin
            $error("Y receive buffer cleared without take");
            errCnt++;
        end

endmodule

//--- routerNode_tb.sv
`include "router_consts.svh"

module routerNode_tb
    import msgPkg::*;
    import busPkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME_BITS     = `MSG_W + 2;
    localparam int FRAME_CNT      = 15;
    localparam int TIMEOUT_CYCLES = FRAME_CNT * 3 * FRAME_BITS + 2000;

    logic        clk_i;
    logic        rst_i;
    logic [2:0]  nodeX_i;
    logic [2:0]  nodeY_i;
    busReq_t     bus_i;
    busRsp_t     bus_o;
    logic        rxdX_i;
    logic        rxdY_i;
    logic        txdX_o;
    logic        txdY_o;
    msg_t        xQ[$];             // decoded from txdX_o
    msg_t        yQ[$];             // decoded from txdY_o
    logic [15:0] lfsrState = 16'd90;

    routerNode uut (.*);

    bind routerNode routerNode_chk chk (
        .clk_i(clk_i), .rst_i(rst_i), .busReq_i(bus_i), .busRsp_i(bus_o),
        .txdX_i(txdX_o), .txdY_i(txdY_o), .txXEmpty_i(txXEmpty), .txYEmpty_i(txYEmpty),
        .txXLoad_i(txXLoad), .txYLoad_i(txYLoad), .fifoPush_i(fifoPush),
        .fifoFull_i(fifoFull), .rxXPresent_i(rxXPresent), .rxYPresent_i(rxYPresent),
        .rxXTake_i(rxXTake), .rxYTake_i(rxYTake)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "stopped at the first error");
    endtask

    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [63:0] randomBits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);    // one step per bit
            v = {v[62:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic logic [7:0] dstOf(input logic [2:0] x, input logic [2:0] y);
        return {x, 1'b0, y, 1'b0};
    endfunction

    function automatic msg_t makeMsg(input logic [7:0] dst, input logic [31:0] route,
                                     input logic [7:0] ctrl, input logic [7:0] age);
        msg_t        m;
        logic [63:0] r;
        {m.dstX, m.padX, m.dstY, m.padY} = dst;
        r         = randomBits(8);
        m.src     = r[7:0];
        m.route   = route;
        m.ctrl    = ctrl;
        m.age     = age;
        m.payload = randomBits(64);
        return m;
    endfunction

    task automatic checkMsg(input msg_t got, input msg_t exp, input string what);
        assert (got === exp) else
            abortRun($sformatf("Fail at %0t ns: %s, got %h, expected %h",
                               $time, what, got, exp));
    endtask

    task automatic checkByte(input logic [7:0] got, input logic [7:0] exp,
                             input string what);
        assert (got === exp) else
            abortRun($sformatf("Fail at %0t ns: %s, got %h, expected %h",
                               $time, what, got, exp));
    endtask

    // ------------------------------------------------------------
    // serial links
    // ------------------------------------------------------------
    task automatic driveLine(input bit onY, input logic v);
        @(posedge clk_i);
        #1;
        if (onY)
            rxdY_i = v;
        else
            rxdX_i = v;
    endtask

    task automatic sendFrame(input bit onY, input msg_t m);
        logic [`MSG_W-1:0] bits;
        bits = m;
        driveLine(onY, 1'b0);           // start
        for (int i = 0; i < `MSG_W; i++)
            driveLine(onY, bits[i]);    // lsb first
        driveLine(onY, 1'b1);           // stop
    endtask

    task automatic captureFrame(input bit onY, output msg_t m);
        logic [`MSG_W-1:0] bits;
        logic              stopBit;
        for (int i = 0; i < `MSG_W; i++) begin
            @(negedge clk_i);
            bits[i] = onY ? txdY_o : txdX_o;
        end
        @(negedge clk_i);
        stopBit = onY ? txdY_o : txdX_o;
        assert (stopBit === 1'b1) else
            abortRun($sformatf("Stop bit missing on transmit line %s", onY ? "Y" : "X"));
        m = msg_t'(bits);
    endtask

    initial begin : decodeX
        msg_t m;
        forever begin
            @(negedge clk_i);
            if (!rst_i && txdX_o === 1'b0) begin
                captureFrame(1'b0, m);
                xQ.push_back(m);
            end
        end
    end

    initial begin : decodeY
        msg_t m;
        forever begin
            @(negedge clk_i);
            if (!rst_i && txdY_o === 1'b0) begin
                captureFrame(1'b1, m);
                yQ.push_back(m);
            end
        end
    end

    task automatic expectFrame(input bit onY, input msg_t exp, input string what);
        msg_t got;
        while ((onY ? yQ.size() : xQ.size()) == 0)
            @(negedge clk_i);
        if (onY)
            got = yQ.pop_front();
        else
            got = xQ.pop_front();
        checkMsg(got, exp, what);
    endtask

    // ------------------------------------------------------------
    // host bus
    // ------------------------------------------------------------
    task automatic busWrite(input logic [7:0] adr, input logic [7:0] dat);
        @(posedge clk_i);
        #1;
        bus_i = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
        @(posedge clk_i);
        #1;
        bus_i = '0;
    endtask

    task automatic busRead(input logic [7:0] adr, output logic [7:0] dat);
        @(posedge clk_i);
        #1;
        bus_i = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 8'h00};
        @(negedge clk_i);
        dat = bus_o.dat;                // ack is combinational
        @(posedge clk_i);
        #1;
        bus_i = '0;
    endtask

    task automatic readHead(output msg_t m);
        logic [`MSG_W-1:0] bits;
        logic [7:0]        b;
        for (int n = 0; n < 16; n++) begin
            busRead(8'(n), b);
            bits[n*8 +: 8] = b;
        end
        m = msg_t'(bits);
    endtask

    task automatic writeHostMsg(input msg_t m);
        logic [`MSG_W-1:0] bits;
        bits = m;
        for (int n = 0; n < 16; n++)
            busWrite(8'(n), bits[n*8 +: 8]);
    endtask

    task automatic waitForDelivery();
        logic [7:0] stat;
        stat = 8'h00;
        while (stat[0] !== 1'b1)
            busRead(`REG_POP, stat);
    endtask

    // ------------------------------------------------------------
    // watchdog and bound assertion monitor
    // ------------------------------------------------------------
    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk_i);
        abortRun($sformatf("Timeout: run still busy after %0d cycles", TIMEOUT_CYCLES));
    end

    always @(negedge clk_i) begin
        if (uut.chk.errCnt != 0)
            abortRun("A protocol assertion bound to the router node failed");
    end

    // ------------------------------------------------------------
    // scenarios
    // ------------------------------------------------------------
    initial begin : scenarios
        msg_t       sent;
        msg_t       other;
        msg_t       exp;
        msg_t       got;
        msg_t       fill [5];
        logic [7:0] stat;
        rst_i   = 1'b1;
        rxdX_i  = 1'b1;
        rxdY_i  = 1'b1;
        bus_i   = '0;
        nodeX_i = 3'd2;
        nodeY_i = 3'd3;
        repeat (4) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        // x before y
        sent = makeMsg(dstOf(3'd5, 3'd1), 32'h0000_0003, CTRL_NORMAL, 8'h07);
        sendFrame(1'b1, sent);
        exp       = sent;
        exp.age   = sent.age + 8'd1;
        exp.route = {sent.route[29:0], 2'b01};
        expectFrame(1'b0, exp, "forward along X");
        sent = makeMsg(dstOf(3'd2, 3'd6), 32'h0000_0001, CTRL_NORMAL, 8'h02);
        sendFrame(1'b0, sent);
        exp       = sent;
        exp.age   = sent.age + 8'd1;
        exp.route = {sent.route[29:0], 2'b10};
        expectFrame(1'b1, exp, "forward along Y");

        // local delivery through the byte window
        sent = makeMsg(dstOf(3'd2, 3'd3), 32'h0000_0009, CTRL_NORMAL, 8'h03);
        sendFrame(1'b0, sent);
        waitForDelivery();
        readHead(got);
        exp     = sent;
        exp.age = sent.age + 8'd1;
        checkMsg(got, exp, "local FIFO head");
        busRead(`REG_POP, stat);
        checkByte(stat, 8'h01, "FIFO status before pop");
        busWrite(`REG_POP, 8'h00);
        busRead(`REG_POP, stat);
        checkByte(stat, 8'h00, "FIFO status after pop");

        // host broadcast keeps its age
        sent = makeMsg(`BCAST_DST, 32'h0000_00A5, CTRL_NORMAL, 8'h05);
        writeHostMsg(sent);
        busWrite(`REG_SEND, 8'h01);
        exp       = sent;
        exp.route = {sent.route[29:0], 2'b01};
        expectFrame(1'b0, exp, "broadcast on X");
        exp.route = {sent.route[29:0], 2'b10};
        expectFrame(1'b1, exp, "broadcast on Y");
        busRead(`REG_SEND, stat);
        checkByte(stat, 8'h00, "send pending after broadcast");

        // forced mode follows the record
        sent = makeMsg(dstOf(3'd5, 3'd5), 32'h8000_0001, CTRL_FORCED, 8'h02);
        sendFrame(1'b1, sent);
        exp       = sent;
        exp.age   = sent.age + 8'd1;
        exp.route = {sent.route[29:0], 2'b00};
        expectFrame(1'b1, exp, "forced hop along Y");
        sent = makeMsg(dstOf(3'd6, 3'd1), 32'h0ABC_0000, CTRL_FORCED, 8'h04);
        sendFrame(1'b0, sent);
        waitForDelivery();
        readHead(got);
        exp     = sent;
        exp.age = sent.age + 8'd1;
        checkMsg(got, exp, "forced local delivery");
        busWrite(`REG_POP, 8'h00);

        // too old is dropped silently
        sent = makeMsg(dstOf(3'd5, 3'd3), 32'h0000_0000, CTRL_NORMAL, `AGE_LIMIT + 8'd1);
        sendFrame(1'b0, sent);
        repeat (400) @(posedge clk_i);
        assert (xQ.size() == 0 && yQ.size() == 0) else
            abortRun($sformatf("Fail at %0t ns: frame over the age limit left the node",
                               $time));
        busRead(`REG_POP, stat);
        checkByte(stat, 8'h00, "FIFO status after aged-out frame");
        sent = makeMsg(dstOf(3'd5, 3'd3), 32'h0000_0000, CTRL_NORMAL, `AGE_LIMIT);
        sendFrame(1'b0, sent);
        exp       = sent;
        exp.age   = `AGE_LIMIT + 8'd1;
        exp.route = {sent.route[29:0], 2'b01};
        expectFrame(1'b0, exp, "frame at the age limit");

        // X link wins when both links deliver at once
        sent  = makeMsg(dstOf(3'd5, 3'd0), 32'h0000_0011, CTRL_NORMAL, 8'h01);
        other = makeMsg(dstOf(3'd6, 3'd2), 32'h0000_0022, CTRL_NORMAL, 8'h06);
        fork
            sendFrame(1'b0, sent);
            sendFrame(1'b1, other);
        join
        exp       = sent;
        exp.age   = sent.age + 8'd1;
        exp.route = {sent.route[29:0], 2'b01};
        expectFrame(1'b0, exp, "first of two X frames");
        exp       = other;
        exp.age   = other.age + 8'd1;
        exp.route = {other.route[29:0], 2'b01};
        expectFrame(1'b0, exp, "second of two X frames");

        // fifth local frame waits in the engine until a pop
        for (int i = 0; i < 5; i++) begin
            fill[i] = makeMsg(dstOf(3'd2, 3'd3), 32'(i), CTRL_NORMAL, 8'(i));
            sendFrame(1'b0, fill[i]);
        end
        for (int i = 0; i < 5; i++) begin
            waitForDelivery();
            readHead(got);
            exp     = fill[i];
            exp.age = fill[i].age + 8'd1;
            checkMsg(got, exp, $sformatf("FIFO entry %0d", i));
            busWrite(`REG_POP, 8'h00);
        end
        busRead(`REG_POP, stat);
        checkByte(stat, 8'h00, "FIFO status after draining");

        repeat (10) @(posedge clk_i);
        if (uut.chk.errCnt == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            abortRun("A protocol assertion bound to the router node failed");
        end
    end

endmodule

//--- router_consts.svh
`ifndef ROUTER_CONSTS_SVH
`define ROUTER_CONSTS_SVH

// ------------------------------------------------------------
// message format
// ------------------------------------------------------------
`define MSG_W        128     // bits per message
`define AGE_LIMIT    8'h40   // oldest age still forwarded
`define BCAST_DST    8'hFF   // destination byte for broadcast

// ------------------------------------------------------------
// local delivery
// ------------------------------------------------------------
`define LFIFO_DEPTH  4       // messages held for the host

// ------------------------------------------------------------
// host register map
// ------------------------------------------------------------
// 0x00..0x0F is the byte window onto the message
`define REG_POP      8'h10   // rd: fifo not empty, wr: pop
`define REG_SEND     8'h12   // rd: send pending, wr: start send

`endif
